//--- Makefile
# Verilator build and run for the SCSI DMA longword FIFO

VERILATOR ?= verilator
TOP       ?= sdmac_fifo_tb
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -j 0

# Sources named in the file list, without option lines
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Passes only when the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^NO ERRORS$$'

clean:
	rm -rf obj_dir

//--- sim/sdmac_fifo_props.sv
`timescale 1ns/100ps

// Flag and occupancy properties of the full and empty counter
module sdmac_fifo_props (
  input logic                 DECFIFO,
  input logic                 RST_FIFO_,
  input logic                 push_en,
  input logic                 pop_en,
  input logic                 fifo_empty,
  input logic                 fifo_full,
  input sdmac_fifo_pkg::occ_t occ
);

  // The FIFO cannot be empty and full at once
  flags_exclusive: assert property (@(posedge DECFIFO) disable iff (!RST_FIFO_)
    !(fifo_empty && fifo_full))
  else $error("fifo_empty and fifo_full are high together");

  // Pushes are refused while full
  no_push_when_full: assert property (@(posedge DECFIFO) disable iff (!RST_FIFO_)
    fifo_full |-> !push_en)
  else $error("push_en is high while fifo_full is high");

  // Pops are refused while empty
  no_pop_when_empty: assert property (@(posedge DECFIFO) disable iff (!RST_FIFO_)
    fifo_empty |-> !pop_en)
  else $error("pop_en is high while fifo_empty is high");

  // Occupancy stays within the eight entries
  occ_in_range: assert property (@(posedge DECFIFO) disable iff (!RST_FIFO_)
    occ <= sdmac_fifo_pkg::occ_t'(sdmac_fifo_pkg::fifo_depth))
  else $error("occupancy exceeds the FIFO depth");

endmodule

bind fifo_flag_ctr sdmac_fifo_props u_props (
  .DECFIFO    (DECFIFO),
  .RST_FIFO_  (RST_FIFO_),
  .push_en    (push_en),
  .pop_en     (pop_en),
  .fifo_empty (fifo_empty),
  .fifo_full  (fifo_full),
  .occ        (occ)
);

//--- sim/sdmac_fifo_tb.sv
`timescale 1ns/100ps

// Testbench for the SCSI DMA longword FIFO
// A queue of stored longwords and a pending-byte model predict rd_data and the flags
module sdmac_fifo_tb;

  // Run limit in cycles, the planned tests need about 2500
  localparam int max_cycles = 4000;

  logic                   DECFIFO;
  logic                   RST_FIFO_;
  logic                   byte_wr;
  sdmac_fifo_pkg::byte_t  wr_byte;
  logic                   flush;
  logic                   rd;
  sdmac_fifo_pkg::lword_t rd_data;
  logic                   fifo_empty;
  logic                   fifo_full;

  // Longwords the model expects in the FIFO, head at index 0
  sdmac_fifo_pkg::lword_t exp_q [$];

  // Bytes gathered so far for the next longword, and how many of them
  sdmac_fifo_pkg::lword_t part_word;
  int                     part_cnt;

  int cycles = 0;

  sdmac_fifo uut (
    .DECFIFO    (DECFIFO),
    .RST_FIFO_  (RST_FIFO_),
    .byte_wr    (byte_wr),
    .wr_byte    (wr_byte),
    .flush      (flush),
    .rd         (rd),
    .rd_data    (rd_data),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full)
  );

  // 100 ns clock period
  initial
  begin
    DECFIFO = 1'b0;
    forever
    begin
      #50;
      DECFIFO = ~DECFIFO;
    end
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    report_failure($sformatf("Fail %s expected %h got %h", name, exp_val, act_val));
  endtask

  // Apply one cycle of inputs shortly after the rising edge
  task automatic drive(input logic bw, input sdmac_fifo_pkg::byte_t b, input logic fl,
                       input logic r);
    @(posedge DECFIFO);
    #5;
    byte_wr = bw;
    wr_byte = b;
    flush   = fl;
    rd      = r;
  endtask

  task automatic write_bytes(input int count);
    repeat (count)
    begin
      drive(1'b1, sdmac_fifo_pkg::byte_t'($urandom), 1'b0, 1'b0);
    end
  endtask

  // Read until the DUT reports empty, one read while empty is harmless
  task automatic drain();
    drive(1'b0, '0, 1'b0, 1'b0);
    while (!fifo_empty)
    begin
      drive(1'b0, '0, 1'b0, 1'b1);
    end
    drive(1'b0, '0, 1'b0, 1'b0);
  endtask

  // Reference model, applies the FIFO rules to the inputs of the cycle ending now
  always @(posedge DECFIFO)
  begin
    logic                   was_full;
    logic                   was_empty;
    logic                   push_now;
    sdmac_fifo_pkg::lword_t push_word;
    if (!RST_FIFO_)
    begin
      exp_q.delete();
      part_word = '0;
      part_cnt  = 0;
    end
    else
    begin
      // Both decisions use the state at the start of the cycle
      was_full  = (exp_q.size() == sdmac_fifo_pkg::fifo_depth);
      was_empty = (exp_q.size() == 0);
      push_now  = 1'b0;
      push_word = '0;
      if (byte_wr)
      begin
        // First byte goes to the most significant lane
        part_word[31 - 8 * part_cnt -: 8] = wr_byte;
        part_cnt++;
      end
      if (part_cnt == 4 || (flush && part_cnt > 0))
      begin
        push_now  = 1'b1;
        push_word = part_word;
        part_word = '0;
        part_cnt  = 0;
      end
      if (rd && !was_empty)
        void'(exp_q.pop_front());
      // A push offered while full is lost for good
      if (push_now && !was_full)
        exp_q.push_back(push_word);
    end
  end

  // Outputs are compared half a cycle after the edge, when they are settled
  always @(negedge DECFIFO)
  begin
    logic exp_empty;
    logic exp_full;
    if (RST_FIFO_)
    begin
      exp_empty = (exp_q.size() == 0);
      exp_full  = (exp_q.size() == sdmac_fifo_pkg::fifo_depth);
      assert (fifo_empty == exp_empty)
      else report_mismatch("fifo_empty", 32'(exp_empty), 32'(fifo_empty));
      assert (fifo_full == exp_full)
      else report_mismatch("fifo_full", 32'(exp_full), 32'(fifo_full));
      assert (uut.u_ctr.occ == sdmac_fifo_pkg::occ_t'(exp_q.size()))
      else report_mismatch("occ", 32'(exp_q.size()), 32'(uut.u_ctr.occ));
      if (!fifo_empty && exp_q.size() != 0)
      begin
        assert (rd_data == exp_q[0])
        else report_mismatch("rd_data", exp_q[0], rd_data);
      end
    end
  end

  always @(posedge DECFIFO)
  begin
    cycles++;
    if (cycles >= max_cycles)
      report_failure($sformatf("Timeout after %0d cycles before the tests finished", cycles));
  end

  initial
  begin
    // Read weight out of 16 for each random phase, low weights let the FIFO fill
    int rd_weight [4] = '{1, 6, 2, 9};
    RST_FIFO_ = 1'b0;
    byte_wr   = 1'b0;
    wr_byte   = '0;
    flush     = 1'b0;
    rd        = 1'b0;
    void'($urandom(32'h917d));
    repeat (10) @(posedge DECFIFO);
    #5;
    RST_FIFO_ = 1'b1;

    // A read right after reset must leave the flags alone
    drive(1'b0, '0, 1'b0, 1'b1);
    drive(1'b0, '0, 1'b0, 1'b0);

    // One full longword from four bytes
    write_bytes(4);
    drain();

    // Partial longwords closed by a flush
    for (int n = 1; n <= 3; n++)
    begin
      write_bytes(n);
      drive(1'b0, '0, 1'b1, 1'b0);
      drain();
    end
    // Flush together with the last byte, then a flush with nothing pending
    write_bytes(2);
    drive(1'b1, sdmac_fifo_pkg::byte_t'($urandom), 1'b1, 1'b0);
    drive(1'b0, '0, 1'b1, 1'b0);
    drain();

    // Fill all eight entries, then offer one longword too many
    write_bytes(32);
    write_bytes(4);
    drain();

    // Random traffic in four phases with different read rates
    for (int phase = 0; phase < 4; phase++)
    begin
      repeat (500)
      begin
        drive(($urandom % 2) == 0, sdmac_fifo_pkg::byte_t'($urandom), ($urandom % 8) == 0,
              ($urandom % 16) < rd_weight[phase]);
      end
    end
    // Push out any leftover bytes before the final drain
    drive(1'b0, '0, 1'b1, 1'b0);
    drain();

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- src.f
src/sdmac_fifo_pkg.sv
src/fifo_byte_pack.sv
src/fifo_flag_ctr.sv
src/fifo_store.sv
src/sdmac_fifo.sv
sim/sdmac_fifo_props.sv
sim/sdmac_fifo_tb.sv

//--- src/fifo_byte_pack.sv
`timescale 1ns/100ps

// Packs SCSI bytes big-endian into longwords
// The first byte of a longword lands in the top lane and later bytes fill downwards
module fifo_byte_pack (
  input  logic                        DECFIFO,
  input  logic                        RST_FIFO_,
  input  logic                        byte_wr,
  input  sdmac_fifo_pkg::byte_t       wr_byte,
  input  logic                        flush,
  output sdmac_fifo_pkg::lword_push_t push
);

  // Next lane to be filled, 0 means the top byte of the longword
  sdmac_fifo_pkg::lane_t lane;

  // High while at least one byte of a longword is waiting
  logic pending;

  // Bytes already received for the current longword, lanes 0 to 2
  sdmac_fifo_pkg::byte_t hold [0:2];

  // Longword as it would look if offered this cycle, index 0 is the top lane
  sdmac_fifo_pkg::byte_t asm_lanes [0:3];

  // Assemble held bytes, the byte arriving now, and zero padding below them
  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      asm_lanes[i] = '0;
    end
    for (int i = 0; i < 3; i++)
    begin
      // Only lanes already filled carry held data, stale bytes stay hidden
      if (sdmac_fifo_pkg::lane_t'(i) < lane)
      begin
        asm_lanes[i] = hold[i];
      end
    end
    // A byte strobed in the same cycle as a flush is part of the longword
    if (byte_wr)
    begin
      asm_lanes[lane] = wr_byte;
    end
  end

  // Offer the longword on the fourth byte, or on a flush with anything to send
  assign push.req  = (byte_wr && (lane == 2'd3)) || (flush && (pending || byte_wr));
  assign push.data = {asm_lanes[0], asm_lanes[1], asm_lanes[2], asm_lanes[3]};

  // Lane index and pending flag
  always_ff @(posedge DECFIFO or negedge RST_FIFO_)
  begin
    if (!RST_FIFO_)
    begin
      lane    <= '0;
      pending <= 1'b0;
    end
    else if (push.req)
    begin
      // The longword leaves this cycle, start over at the top lane
      lane    <= '0;
      pending <= 1'b0;
    end
    else if (byte_wr)
    begin
      lane    <= lane + 2'd1;
      pending <= 1'b1;
    end
  end

  // Holding register for the first three bytes
  always_ff @(posedge DECFIFO)
  begin
    if (byte_wr && !push.req)
    begin
      case (lane)
        2'd0: hold[0] <= wr_byte;
        2'd1: hold[1] <= wr_byte;
        2'd2: hold[2] <= wr_byte;
        // Lane 3 always completes a longword and is never held
        default: ;
      endcase
    end
  end

endmodule

//--- src/fifo_flag_ctr.sv
`timescale 1ns/100ps

// Full and empty counter for the longword FIFO
// Synchronous form of the ripple counter that counted on INCFIFO and DECFIFO edges
// Here both directions are level strobes sampled on DECFIFO
module fifo_flag_ctr (
  input  logic DECFIFO,
  input  logic RST_FIFO_,
  input  logic push_req,
  input  logic rd,
  output logic push_en,
  output logic pop_en,
  output logic fifo_empty,
  output logic fifo_full
);

  // Number of longwords currently stored
  sdmac_fifo_pkg::occ_t occ;

  // Occupancy after the current cycle's accepted push and pop
  sdmac_fifo_pkg::occ_t occ_next;

  // A push is refused while full and a pop while empty
  // Both decisions use the registered flags only
  assign push_en = push_req && !fifo_full;
  assign pop_en  = rd && !fifo_empty;

  always_comb
  begin
    case ({push_en, pop_en})
      2'b10: occ_next = occ + 4'd1;
      2'b01: occ_next = occ - 4'd1;
      // Push and pop together leave the count alone
      default: occ_next = occ;
    endcase
  end

  // Count and flags move together on the edge that ends the cycle
  // The flags are therefore valid in the cycle after the push or pop
  always_ff @(posedge DECFIFO or negedge RST_FIFO_)
  begin
    if (!RST_FIFO_)
    begin
      occ        <= '0;
      fifo_empty <= 1'b1;
      fifo_full  <= 1'b0;
    end
    else
    begin
      occ        <= occ_next;
      fifo_empty <= (occ_next == '0);
      fifo_full  <= (occ_next == sdmac_fifo_pkg::occ_t'(sdmac_fifo_pkg::fifo_depth));
    end
  end

endmodule

//--- src/fifo_store.sv
`timescale 1ns/100ps

// Eight-entry longword array with a fall-through read port
// The strobes arrive already qualified by the flag counter
module fifo_store (
  input  logic                   DECFIFO,
  input  logic                   RST_FIFO_,
  input  logic                   push_en,
  input  sdmac_fifo_pkg::lword_t wr_data,
  input  logic                   pop_en,
  output sdmac_fifo_pkg::lword_t rd_data
);

  // Longword storage
  sdmac_fifo_pkg::lword_t mem [sdmac_fifo_pkg::fifo_depth];

  // Next entry to write and the current head entry
  sdmac_fifo_pkg::ptr_t wr_ptr;
  sdmac_fifo_pkg::ptr_t rd_ptr;

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge DECFIFO or negedge RST_FIFO_)
  begin
    if (!RST_FIFO_)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (push_en)
      begin
        wr_ptr <= wr_ptr + 3'd1;
      end
      if (pop_en)
      begin
        rd_ptr <= rd_ptr + 3'd1;
      end
    end
  end

  // Write the offered longword at the write pointer
  always_ff @(posedge DECFIFO)
  begin
    if (push_en)
    begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Head longword is always visible
  // When empty it shows whatever stale entry sits at the read pointer
  assign rd_data = mem[rd_ptr];

endmodule

//--- src/sdmac_fifo.sv
`timescale 1ns/100ps

// Longword FIFO between the SCSI byte side and the 32-bit DMA side
// Bytes are packed into longwords, counted in and out, and stored in eight entries
module sdmac_fifo (
  input  logic                   DECFIFO,
  input  logic                   RST_FIFO_,
  input  logic                   byte_wr,
  input  sdmac_fifo_pkg::byte_t  wr_byte,
  input  logic                   flush,
  input  logic                   rd,
  output sdmac_fifo_pkg::lword_t rd_data,
  output logic                   fifo_empty,
  output logic                   fifo_full
);

  // Longword offered by the packer
  sdmac_fifo_pkg::lword_push_t push;

  // Push and pop after the flag checks
  logic push_en;
  logic pop_en;

  // Byte side, packs SCSI bytes into longwords
  fifo_byte_pack u_pack (
    .DECFIFO   (DECFIFO),
    .RST_FIFO_ (RST_FIFO_),
    .byte_wr   (byte_wr),
    .wr_byte   (wr_byte),
    .flush     (flush),
    .push      (push)
  );

  // Occupancy and the full and empty flags
  fifo_flag_ctr u_ctr (
    .DECFIFO    (DECFIFO),
    .RST_FIFO_  (RST_FIFO_),
    .push_req   (push.req),
    .rd         (rd),
    .push_en    (push_en),
    .pop_en     (pop_en),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full)
  );

  // Longword storage, head visible on rd_data
  fifo_store u_store (
    .DECFIFO   (DECFIFO),
    .RST_FIFO_ (RST_FIFO_),
    .push_en   (push_en),
    .wr_data   (push.data),
    .pop_en    (pop_en),
    .rd_data   (rd_data)
  );

endmodule

//--- src/sdmac_fifo_pkg.sv
// Shared widths and types for the SCSI DMA longword FIFO
// The FIFO sits between the byte-wide SCSI side and the 32-bit DMA side
package sdmac_fifo_pkg;

  // Number of longword entries held by the store
  localparam int fifo_depth = 8;

  // One byte as it arrives from the SCSI side
  typedef logic [7:0] byte_t;

  // One FIFO entry, packed big-endian from four SCSI bytes
  typedef logic [31:0] lword_t;

  // Byte lane index inside a longword, lane 0 is the most significant byte
  typedef logic [1:0] lane_t;

  // Read and write pointers of the store, wrapping at fifo_depth
  typedef logic [2:0] ptr_t;

  // Occupancy of the FIFO, needs one extra bit to hold the value 8
  typedef logic [3:0] occ_t;

  // Push request from the byte packer
  // req is high in the cycle a complete or flushed longword is offered
  typedef struct packed {
    logic   req;
    lword_t data;
  } lword_push_t;

endpackage
